// File: testbench/lcd_bench_tests.txt
// rs byte dbl, in hex: rs 0 = command, 1 = data; dbl 1 = second strobe while busy
// a line with rs ff ends the list
00 28 00
00 0c 00
00 06 01
00 01 00
01 48 00
01 65 01
01 6c 00
01 6c 01
01 6f 00
00 c0 01
01 a5 00
01 5a 01
00 80 00
01 ff 00
01 00 01
00 33 00
01 3c 01
00 02 00
01 7e 00
ff ff ff

// File: lcd_bench.f
+incdir+hdl
hdl/lcd_bench_pkg.sv
hdl/lcd_nybble_sender.sv
hdl/lcd_byte_sender.sv
hdl/alive_blinker.sv
hdl/lcd_bench_top.sv
testbench/lcd_bench_tb.sv

// File: Bender.yml
package:
  name: lcd_bench

export_include_dirs:
  - hdl

sources:
  # rtl, package first
  - include_dirs:
      - hdl
    files:
      - hdl/lcd_bench_pkg.sv
      - hdl/lcd_nybble_sender.sv
      - hdl/lcd_byte_sender.sv
      - hdl/alive_blinker.sv
      - hdl/lcd_bench_top.sv

  # testbench
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/lcd_bench_tb.sv

// File: testbench/lcd_bench_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "lcd_bench_macros.svh"

module lcd_bench_tb
    import lcd_bench_pkg::*;
();

    localparam int CLK_HALF   = 50;                 // 100 ns clock
    localparam int DRIVE_DLY  = 2;                  // inputs move this long after the edge
    localparam int SAMPLE_DLY = 1;                  // outputs settled by now
    localparam int MAX_TESTS  = 64;
    localparam int PWM_PERIOD = 1 << `PWM_BITS;
    localparam int RGB_WINDOW = PWM_PERIOD * 16;

    logic           clk;
    logic           i_reset;
    logic           i_button;
    logic           i_stb;
    logic           i_rs;
    lcd_byte_t      i_byte;
    logic           o_busy;
    lcd_pins_t      o_lcd;
    logic           o_logan_strobe;
    logic [2:0]     o_led_rgb;
    logic [3:0]     o_led_ext;

    lcd_byte_t  test_mem [0:3*MAX_TESTS-1];         // rs, byte, dbl per test
    int         n_tests;
    int         err_cnt;
    int         test_err_base;
    int         tests_run;
    int         tests_failed;
    string      test_name;

    // one entry per E pulse
    logic       rise_rs[$];
    nybble_t    rise_data[$];
    int         rise_stable[$];                     // clocks rs/data held before the rise
    int         rise_gap[$];                        // clocks since the previous rise
    int         pulse_width[$];

    int         cyc_cnt    = 0;
    int         last_rise  = -1000;
    int         stable_cnt = 0;
    int         high_cnt   = 0;
    logic       prev_e     = 1'b0;
    logic [4:0] prev_rd    = '0;

    lcd_bench_top DUT (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_button       (i_button),
        .i_stb          (i_stb),
        .i_rs           (i_rs),
        .i_byte         (i_byte),
        .o_busy         (o_busy),
        .o_lcd          (o_lcd),
        .o_logan_strobe (o_logan_strobe),
        .o_led_rgb      (o_led_rgb),
        .o_led_ext      (o_led_ext)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ******************************
    // lcd pin monitor
    // ******************************

    always begin
        @(posedge clk);
        #SAMPLE_DLY;
        cyc_cnt++;
        if ({o_lcd.rs, o_lcd.data} !== prev_rd) begin
            stable_cnt = 0;                         // rs or data just moved
        end else begin
            stable_cnt++;
        end
        if (o_lcd.e === 1'b1 && prev_e !== 1'b1) begin
            rise_rs.push_back(o_lcd.rs);
            rise_data.push_back(o_lcd.data);
            rise_stable.push_back(stable_cnt);
            rise_gap.push_back(cyc_cnt - last_rise);
            last_rise = cyc_cnt;
            high_cnt  = 0;
        end
        if (o_lcd.e === 1'b1) begin
            high_cnt++;
        end else if (prev_e === 1'b1) begin
            pulse_width.push_back(high_cnt);        // E just fell
        end
        prev_rd = {o_lcd.rs, o_lcd.data};
        prev_e  = o_lcd.e;
    end

    // ******************************
    // helpers
    // ******************************

    task automatic next_drive_slot;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic next_sample_slot;
        @(posedge clk);
        #SAMPLE_DLY;
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_true(input bit ok, input string what);
        assert (ok) else begin
            $display("Error: %s", what);
            err_cnt++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        test_err_base = err_cnt;
    endtask

    task automatic end_test;
        tests_run++;
        if (err_cnt != test_err_base) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, test_name,
                 (err_cnt == test_err_base) ? "pass" : "FAIL");
    endtask

    task automatic clear_record;
        rise_rs.delete();
        rise_data.delete();
        rise_stable.delete();
        rise_gap.delete();
        pulse_width.delete();
    endtask

    task automatic wait_busy(input logic level, input int limit, output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < limit) begin
            next_sample_slot();
            ok = (o_busy === level);
            n++;
        end
    endtask

    // ******************************
    // tests
    // ******************************

    // sender held in reset so a strobe changes nothing
    task automatic run_unarmed;
        int n;
        clear_record();
        next_drive_slot();
        i_rs   = 1'b1;
        i_byte = 8'h5A;
        i_stb  = 1'b1;
        next_drive_slot();
        i_stb  = 1'b0;
        for (n = 0; n < 2 * `LCD_TICKS_TCYCE; n++) begin
            next_sample_slot();
            check_eq("o_busy", o_busy, 0);
            check_eq("o_lcd", o_lcd, 0);            // E, rs and data all low
            check_eq("o_logan_strobe", o_logan_strobe, 0);
            check_eq("o_led_ext", o_led_ext, 4'hF);
        end
        check_true(rise_data.size() == 0, "E rose while the bench was unarmed");
    endtask

    task automatic run_arm;
        int n;
        bit seen;
        next_drive_slot();
        i_button = 1'b1;
        next_drive_slot();
        i_button = 1'b0;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < 8) begin
            next_sample_slot();
            seen = (o_logan_strobe === 1'b1);
            n++;
        end
        check_true(seen, "logic analyzer strobe did not rise after the button");
        repeat (8) begin
            next_sample_slot();
            check_eq("o_logan_strobe", o_logan_strobe, 1);  // sticky after release
        end
        seen = 1'b0;
        n    = 0;
        while (!seen && n < (1 << `ALIVE_BITS)) begin
            next_sample_slot();
            seen = (o_led_ext !== 4'hF) && !$isunknown(o_led_ext);
            n++;
        end
        check_true(seen, "external LEDs did not start changing after arming");
    endtask

    // high nybble first, same rs on both, hd44780 timing on E
    task automatic run_byte(input logic rs, input lcd_byte_t b, input bit dbl);
        bit ok;
        int k;
        clear_record();
        next_drive_slot();
        i_rs   = rs;
        i_byte = b;
        i_stb  = 1'b1;
        next_drive_slot();
        i_stb  = 1'b0;
        wait_busy(1'b1, 8, ok);
        check_true(ok, "busy did not rise after the strobe");
        if (dbl) begin
            next_drive_slot();
            check_true(o_busy === 1'b1, "sender not busy when the second strobe went out");
            i_rs   = ~rs;                           // different request that must be dropped
            i_byte = ~b;
            i_stb  = 1'b1;
            next_drive_slot();
            i_stb  = 1'b0;
        end
        wait_busy(1'b0, 4 * `LCD_TICKS_TCYCE, ok);
        check_true(ok, "busy still high at the timeout");
        check_true(rise_data.size() == 2,
                   $sformatf("expected 2 pulses of E, saw %0d", rise_data.size()));
        check_true(pulse_width.size() == 2,
                   $sformatf("expected 2 falls of E, saw %0d", pulse_width.size()));
        if (rise_data.size() == 2 && pulse_width.size() == 2) begin
            check_eq("o_lcd.data high nybble", rise_data[0], b[7:4]);
            check_eq("o_lcd.data low nybble", rise_data[1], b[3:0]);
            for (k = 0; k < 2; k++) begin
                check_eq("o_lcd.rs", rise_rs[k], rs);
                check_true(pulse_width[k] == `LCD_TICKS_PWEH,
                           $sformatf("E pulse %0d was %0d clocks wide", k, pulse_width[k]));
                check_true(rise_stable[k] >= `LCD_TICKS_TAS,
                           $sformatf("rs/data held only %0d clocks before E pulse %0d",
                                     rise_stable[k], k));
            end
            check_true(rise_gap[1] >= `LCD_TICKS_TCYCE,
                       $sformatf("rises of E only %0d clocks apart", rise_gap[1]));
        end
    endtask

    task automatic run_rgb;
        int n;
        int k;
        int flag_cnt [0:2];
        logic [2:0] prev;
        for (k = 0; k < 3; k++) begin
            flag_cnt[k] = 0;
        end
        next_sample_slot();
        prev = o_led_rgb;
        for (n = 0; n < RGB_WINDOW; n++) begin
            next_sample_slot();
            for (k = 0; k < 3; k++) begin
                check_true(!(o_led_rgb[k] === 1'b1 && prev[k] === 1'b1),
                           $sformatf("rgb flag %0d high on two clocks in a row", k));
                if (o_led_rgb[k] === 1'b1) begin
                    flag_cnt[k]++;
                end
            end
            prev = o_led_rgb;
        end
        for (k = 0; k < 3; k++) begin
            check_true(flag_cnt[k] <= RGB_WINDOW / PWM_PERIOD,
                       $sformatf("rgb flag %0d high on %0d of %0d clocks",
                                 k, flag_cnt[k], RGB_WINDOW));
        end
    endtask

    // ******************************
    // main sequence
    // ******************************

    initial begin
        int t;
        lcd_byte_t f_rs;
        lcd_byte_t f_byte;
        lcd_byte_t f_dbl;
        i_reset      = 1'b1;
        i_button     = 1'b0;
        i_stb        = 1'b0;
        i_rs         = 1'b0;
        i_byte       = '0;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(12495));

        $readmemh("testbench/lcd_bench_tests.txt", test_mem);
        n_tests = 0;
        // list ends at the first rs field that is not 0 or 1
        while (n_tests < MAX_TESTS &&
               (test_mem[3*n_tests] === 8'h00 || test_mem[3*n_tests] === 8'h01)) begin
            n_tests++;
        end
        check_true(n_tests > 0, "no tests read from the test file");

        repeat (16) @(posedge clk);
        #DRIVE_DLY;
        i_reset = 1'b0;

        begin_test("unarmed quiet");
        run_unarmed();
        end_test();

        begin_test("arming");
        run_arm();
        end_test();

        for (t = 0; t < n_tests; t++) begin
            f_rs   = test_mem[3*t];
            f_byte = test_mem[3*t+1];
            f_dbl  = test_mem[3*t+2];
            begin_test($sformatf("byte rs %0h data 0x%02h%s", f_rs[0], f_byte,
                                 f_dbl[0] ? " double strobe" : ""));
            run_byte(f_rs[0], f_byte, f_dbl[0]);
            end_test();
            repeat (1 + $urandom % 8) next_drive_slot();  // idle gap
        end

        begin_test("rgb dimming");
        run_rgb();
        end_test();

        $display("%0d tests run, %0d passed, %0d failed, %0d checks wrong",
                 tests_run, tests_run - tests_failed, tests_failed, err_cnt);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/lcd_bench_top.sv
`timescale 1ns/100ps
`default_nettype none

module lcd_bench_top
    import lcd_bench_pkg::*;
(
    input  wire            clk,
    input  wire            i_reset,
    input  wire            i_button,        // active high, undebounced
    input  wire            i_stb,           // host byte request
    input  wire            i_rs,
    input  wire lcd_byte_t i_byte,
    output logic           o_busy,
    output lcd_pins_t      o_lcd,
    output logic           o_logan_strobe,  // logic analyzer trigger, sticky
    output logic [2:0]     o_led_rgb,       // green, blue, red
    output logic [3:0]     o_led_ext        // active low
);

    logic armed;            // button seen since reset
    logic sender_reset;

    // ******************************
    // arm latch
    // ******************************
    // first press arms the bench and fires the analyzer trigger;
    // no debounce, later bounces change nothing

    always_ff @(posedge clk) begin
        if (i_reset) begin
            armed          <= 1'b0;
            o_logan_strobe <= 1'b0;
        end else if (i_button) begin
            armed          <= 1'b1;
            o_logan_strobe <= 1'b1;
        end
    end

    // lcd path held in reset until armed, so the analyzer catches it all
    assign sender_reset = i_reset | ~armed;

    lcd_byte_sender u_byte_sender (
        .clk     (clk),
        .i_reset (sender_reset),
        .i_stb   (i_stb),
        .i_rs    (i_rs),
        .i_byte  (i_byte),
        .o_busy  (o_busy),
        .o_lcd   (o_lcd)
    );

    alive_blinker u_alive_blinker (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_armed   (armed),
        .o_led_rgb (o_led_rgb),
        .o_led_ext (o_led_ext)
    );

    // the trigger only drops through a real reset
    a_logan_sticky: assert property (
        @(posedge clk)
        $fell(o_logan_strobe) |-> $past(i_reset)
    ) else $error("logan strobe fell without reset");

endmodule

`default_nettype wire

// File: hdl/alive_blinker.sv
`timescale 1ns/100ps
`default_nettype none

`include "lcd_bench_macros.svh"

module alive_blinker (
    input  wire        clk,
    input  wire        i_reset,
    input  wire        i_armed,         // external LEDs dark until armed
    output logic [2:0] o_led_rgb,       // bits 0..2 green, blue, red (active high)
    output logic [3:0] o_led_ext        // active low
);

    localparam int N = `ALIVE_BITS;

    // rgb flags keep blinking through reset
    logic [N-1:0]           alive_cnt = '0;
    logic [`PWM_BITS-1:0]   pwm_cnt   = '0;
    logic [2:0]             rgb_raw;            // undimmed blink pattern
    logic                   pwm_on;

    always_ff @(posedge clk) begin
        alive_cnt <= alive_cnt + 1'b1;
        pwm_cnt   <= pwm_cnt + 1'b1;
    end

    assign rgb_raw[0] = ~alive_cnt[N-1];    // green
    assign rgb_raw[1] =  alive_cnt[N-1];    // blue is the inverse of green
    assign rgb_raw[2] = ~alive_cnt[N-2];    // red at twice the rate
    assign pwm_on     = &pwm_cnt;           // one clock in 2^PWM_BITS

    // ******************************
    // dimmed rgb flags
    // ******************************

    always_ff @(posedge clk) begin
        o_led_rgb <= rgb_raw & {3{pwm_on}};
    end

    // ******************************
    // external LEDs
    // ******************************

    always_ff @(posedge clk) begin
        if (i_reset || !i_armed) begin
            o_led_ext <= 4'b1111;   // all off
        end else begin
            o_led_ext[0] <=  alive_cnt[N-2];
            o_led_ext[1] <= ~alive_cnt[N-3];
            o_led_ext[2] <=  alive_cnt[N-3];
            o_led_ext[3] <= ~alive_cnt[N-4];
        end
    end

    // dimming means a lit flag is always followed by a dark clock
    a_rgb_dimmed: assert property (
        @(posedge clk)
        (|o_led_rgb) |=> !(|o_led_rgb)
    ) else $error("rgb flag high on two consecutive clocks");

endmodule

`default_nettype wire

// File: hdl/lcd_byte_sender.sv
`timescale 1ns/100ps
`default_nettype none

module lcd_byte_sender
    import lcd_bench_pkg::*;
(
    input  wire            clk,
    input  wire            i_reset,
    input  wire            i_stb,       // one clock wide and ignored while busy
    input  wire            i_rs,
    input  wire lcd_byte_t i_byte,
    output logic           o_busy,      // high across both nybbles
    output lcd_pins_t      o_lcd
);

    byte_state_t state;
    lcd_byte_t   byte_q;        // byte being sent
    logic        rs_q;
    logic        accept;
    logic        nyb_stb;       // to the nybble sender
    logic        nyb_busy;
    nybble_t     nyb_data;

    // busy drops together with the low nybble's busy
    assign o_busy = (state != BYTE_IDLE) && !((state == BYTE_WAIT_LOW) && !nyb_busy);
    assign accept = i_stb && !o_busy;

    // strobe only while the nybble sender is idle
    assign nyb_stb  = ((state == BYTE_HIGH) || (state == BYTE_LOW)) && !nyb_busy;
    assign nyb_data = (state == BYTE_LOW) ? byte_q[3:0] : byte_q[7:4];   // high nybble first

    // ******************************
    // request latch
    // ******************************

    always_ff @(posedge clk) begin
        if (accept) begin
            byte_q <= i_byte;
            rs_q   <= i_rs;     // same rs for both halves
        end
    end

    // ******************************
    // sequencing fsm
    // ******************************

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= BYTE_IDLE;
        end else if (accept) begin
            state <= BYTE_HIGH;     // from idle or straight out of wait_low
        end else begin
            case (state)
                BYTE_IDLE:      state <= BYTE_IDLE;
                BYTE_HIGH:      if (!nyb_busy) state <= BYTE_WAIT_HIGH;  // strobe went out
                BYTE_WAIT_HIGH: if (!nyb_busy) state <= BYTE_LOW;        // high half done
                BYTE_LOW:       if (!nyb_busy) state <= BYTE_WAIT_LOW;
                BYTE_WAIT_LOW:  if (!nyb_busy) state <= BYTE_IDLE;
                default:        state <= BYTE_IDLE;
            endcase
        end
    end

    lcd_nybble_sender u_nybble_sender (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_stb    (nyb_stb),
        .i_rs     (rs_q),
        .i_nybble (nyb_data),
        .o_busy   (nyb_busy),
        .o_lcd    (o_lcd)       // straight out to the pins
    );

    // a strobe state always finds the nybble sender idle and makes it busy next clock
    a_stb_taken: assert property (
        @(posedge clk) disable iff (i_reset)
        ((state == BYTE_HIGH) || (state == BYTE_LOW)) |-> !nyb_busy ##1 nyb_busy
    ) else $error("byte fsm reached a strobe state with the nybble sender busy");

endmodule

`default_nettype wire

// File: hdl/lcd_nybble_sender.sv
`timescale 1ns/100ps
`default_nettype none

`include "lcd_bench_macros.svh"

module lcd_nybble_sender
    import lcd_bench_pkg::*;
(
    input  wire          clk,
    input  wire          i_reset,
    input  wire          i_stb,         // one clock, taken only while not busy
    input  wire          i_rs,
    input  wire nybble_t i_nybble,
    output logic         o_busy,
    output lcd_pins_t    o_lcd
);

    nyb_state_t  state;
    tick_count_t count;     // ticks left in the current phase, 0 = last tick
    logic        accept;

    assign accept = i_stb && !o_busy;   // strobes during busy are dropped

    // ******************************
    // timing fsm
    // ******************************
    // strobe at edge t0 -> rs/data at t0, E up at t0+tAS,
    // E down after pweh ticks, busy down tcycE after the rise of E

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state  <= NYB_IDLE;
            count  <= '0;
            o_busy <= 1'b0;
            o_lcd  <= '0;       // E low, rs and data zero
        end else begin
            case (state)
                NYB_IDLE: begin
                    if (accept) begin
                        o_lcd.rs   <= i_rs;         // held until the next accepted strobe
                        o_lcd.data <= i_nybble;
                        count      <= tick_count_t'(`LCD_TICKS_TAS - 1);
                        o_busy     <= 1'b1;
                        state      <= NYB_SETUP;
                    end
                end

                NYB_SETUP: begin
                    if (count == '0) begin
                        o_lcd.e <= 1'b1;            // address setup done
                        count   <= tick_count_t'(`LCD_TICKS_PWEH - 1);
                        state   <= NYB_ENABLE;
                    end else begin
                        count <= count - 1'b1;
                    end
                end

                NYB_ENABLE: begin
                    if (count == '0) begin
                        o_lcd.e <= 1'b0;            // lcd latches data on this fall
                        // remainder of the enable cycle
                        count   <= tick_count_t'(`LCD_TICKS_TCYCE - `LCD_TICKS_PWEH - 1);
                        state   <= NYB_HOLD;
                    end else begin
                        count <= count - 1'b1;
                    end
                end

                NYB_HOLD: begin
                    if (count == '0) begin
                        o_busy <= 1'b0;             // next strobe may come now
                        state  <= NYB_IDLE;
                    end else begin
                        count <= count - 1'b1;
                    end
                end

                default: begin
                    o_lcd.e <= 1'b0;
                    o_busy  <= 1'b0;
                    state   <= NYB_IDLE;
                end
            endcase
        end
    end

    // ******************************
    // checks
    // ******************************

    // E must not be left high once the fsm has gone back to idle
    a_e_low_in_idle: assert property (
        @(posedge clk) disable iff (i_reset)
        (state == NYB_IDLE) |-> !o_lcd.e
    ) else $error("lcd E high while nybble sender idle");

    // rs and data frozen for the whole E pulse
    a_pins_stable_e: assert property (
        @(posedge clk) disable iff (i_reset)
        o_lcd.e |=> (!o_lcd.e || $stable({o_lcd.rs, o_lcd.data}))
    ) else $error("lcd rs/data changed while E high");

endmodule

`default_nettype wire

// File: hdl/lcd_bench_pkg.sv
`default_nettype none

`include "lcd_bench_macros.svh"

package lcd_bench_pkg;

    // ******************************
    // vector types
    // ******************************

    typedef logic [3:0] nybble_t;                           // one half of an lcd byte
    typedef logic [7:0] lcd_byte_t;                         // command or character
    typedef logic [`LCD_COUNT_BITS-1:0] tick_count_t;       // setup / enable / cycle timer

    // ******************************
    // sender state machines
    // ******************************

    typedef enum logic [1:0] {
        NYB_IDLE,       // waiting for a strobe
        NYB_SETUP,      // rs and data out, E low (tAS)
        NYB_ENABLE,     // E high (PWeh)
        NYB_HOLD        // E low again, rest of tcycE
    } nyb_state_t;

    typedef enum logic [2:0] {
        BYTE_IDLE,
        BYTE_HIGH,      // strobe high nybble
        BYTE_WAIT_HIGH,
        BYTE_LOW,       // strobe low nybble
        BYTE_WAIT_LOW
    } byte_state_t;

    // lcd pins, 4-bit bus; R/W is tied low on the board
    typedef struct packed {
        logic    rs;    // register select, 0 = command
        logic    e;     // enable strobe
        nybble_t data;  // DB7..DB4
    } lcd_pins_t;

endpackage

`default_nettype wire

// File: hdl/lcd_bench_macros.svh
`ifndef LCD_BENCH_MACROS_SVH
`define LCD_BENCH_MACROS_SVH

// ******************************
// hd44780 nybble timing, in clk ticks
// ******************************

// rs and data settle before the rising edge of E (tAS)
`define LCD_TICKS_TAS       (3)

// E high width (PWeh)
`define LCD_TICKS_PWEH      (22)

// rising edge of E to the next rising edge (tcycE)
`define LCD_TICKS_TCYCE     (48)

// tick counter width, must hold tcycE - pweh
`define LCD_COUNT_BITS      (6)

// ******************************
// alive blinker
// ******************************

`define ALIVE_BITS          (10)    // small so a sim sees the LEDs move
`define PWM_BITS            (3)     // flags lit 1 clock in 2^PWM_BITS

`endif
